/* hw/rosetta_pkg.sv */
// Shared widths, instruction layout and FSM encodings for the sparse MxV engine
// num_pe and word_w are only defaults, the core takes both as parameters
// acc_w here matches the defaults and mac_array derives its own from its parameters
package rosetta_pkg;

    // Lane count must stay a power of 2
    localparam int num_pe = 8;
    localparam int word_w = 8;

    // Room for a bias plus num_pe full-scale signed products
    localparam int acc_w = 2 * word_w + $clog2(num_pe) + 1;

    typedef logic [31:0] inst_t;
    typedef logic [7:0]  pc_t;
    typedef logic [4:0]  row_addr_t;
    typedef logic [10:0] waddr_t;

    // Instruction field positions
    // Bits 4:0 are reserved and expected to be zero
    localparam int op_msb   = 31;
    localparam int op_lsb   = 30;
    localparam int dst_msb  = 29;
    localparam int dst_lsb  = 25;
    localparam int bias_msb = 24;
    localparam int bias_lsb = 20;
    localparam int x_msb    = 19;
    localparam int x_lsb    = 16;
    localparam int wb_msb   = 15;
    localparam int wb_lsb   = 5;

    typedef enum logic [1:0] {
        op_nop  = 2'd0,
        op_mvma = 2'd1,
        op_halt = 2'd2
    } opcode_e;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_load,
        st_scan,
        st_drain,
        st_write,
        st_halt
    } seq_state_e;

endpackage

/* hw/mac_lane.sv */
`timescale 1ns/1ps
// One signed multiply-accumulate lane
// The result is the accumulator clamped to the signed word_w range
module mac_lane #(
    parameter int word_w = rosetta_pkg::word_w,
    parameter int acc_w  = rosetta_pkg::acc_w
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        bias_load,
    input  logic signed [word_w-1:0]    bias,
    input  logic                        acc_en,
    input  logic signed [word_w-1:0]    act,
    input  logic signed [word_w-1:0]    weight,
    output logic signed [word_w-1:0]    result
);

    localparam logic signed [acc_w-1:0] sat_max = acc_w'((1 << (word_w - 1)) - 1);
    localparam logic signed [acc_w-1:0] sat_min = -sat_max - 1;

    logic signed [acc_w-1:0]      acc_q;
    logic signed [2*word_w-1:0]   prod;

    assign prod = act * weight;

    always_ff @(posedge clk) begin
        if (rst) begin
            acc_q <= '0;
        end else if (bias_load) begin
            acc_q <= {{(acc_w-word_w){bias[word_w-1]}}, bias};
        end else if (acc_en) begin
            acc_q <= acc_q + prod;
        end
    end

    always_comb begin
        if (acc_q > sat_max) begin
            result = sat_max[word_w-1:0];
        end else if (acc_q < sat_min) begin
            result = sat_min[word_w-1:0];
        end else begin
            result = acc_q[word_w-1:0];
        end
    end

endmodule

/* hw/mac_array.sv */
`timescale 1ns/1ps
// Row of MAC lanes fed one broadcast activation element per step
// mac_step and elem_idx are delayed one cycle so they meet wm_rdata
module mac_array #(
    parameter int num_pe = rosetta_pkg::num_pe,
    parameter int word_w = rosetta_pkg::word_w
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        row_load,
    input  logic                        mac_clear,
    input  logic                        mac_step,
    input  logic [$clog2(num_pe)-1:0]   elem_idx,
    input  logic [num_pe*word_w-1:0]    act_row,
    input  logic [num_pe*word_w-1:0]    bias_row,
    input  logic [num_pe*word_w-1:0]    weight_row,
    output logic [num_pe*word_w-1:0]    result_row
);

    localparam int acc_w = 2 * word_w + $clog2(num_pe) + 1;

    logic [num_pe*word_w-1:0]   act_q;
    logic                       step_q;
    logic [$clog2(num_pe)-1:0]  idx_q;
    logic [word_w-1:0]          act_elem;

    always_ff @(posedge clk) begin
        if (row_load) begin
            act_q <= act_row;
        end
        idx_q <= elem_idx;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            step_q <= 1'b0;
        end else begin
            step_q <= mac_step;
        end
    end

    assign act_elem = act_q[idx_q * word_w +: word_w];

    for (genvar k = 0; k < num_pe; k++) begin : g_lane
        mac_lane #(
            .word_w(word_w),
            .acc_w (acc_w)
        ) lane_inst (
            .clk       (clk),
            .rst       (rst),
            .bias_load (mac_clear),
            .bias      (bias_row[k*word_w +: word_w]),
            .acc_en    (step_q),
            .act       (act_elem),
            .weight    (weight_row[k*word_w +: word_w]),
            .result    (result_row[k*word_w +: word_w])
        );
    end

endmodule

/* hw/zero_skip_unit.sv */
`timescale 1ns/1ps
// Remaining presence mask with a leading-zero count over it
// Element k sits at mask bit num_pe-1-k so the leading one is the lowest k
// num_pe must be a power of 2 and at least 2
module zero_skip_unit #(
    parameter int num_pe = rosetta_pkg::num_pe
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        mask_load,
    input  logic                        scan_step,
    input  logic [num_pe-1:0]           mask_in,
    output logic                        elem_valid,
    output logic [$clog2(num_pe)-1:0]   elem_idx,
    output logic                        elem_last
);

    localparam int idx_w = $clog2(num_pe);
    localparam logic [num_pe-1:0] msb_one = {1'b1, {(num_pe-1){1'b0}}};

    logic [num_pe-1:0] mask_q;
    logic [num_pe-1:0] sel;
    logic [num_pe-1:0] rest;

    // Leading-zero count, higher bits come later in the loop and win
    always_comb begin
        elem_idx = '0;
        for (int i = 0; i < num_pe; i++) begin
            if (mask_q[i]) begin
                elem_idx = idx_w'(num_pe - 1 - i);
            end
        end
    end

    assign sel        = msb_one >> elem_idx;
    assign rest       = mask_q & ~sel;
    assign elem_valid = |mask_q;
    // Last element when nothing is left once the current bit is cleared
    assign elem_last  = elem_valid && !(|rest);

    always_ff @(posedge clk) begin
        if (rst) begin
            mask_q <= '0;
        end else if (mask_load) begin
            mask_q <= mask_in;
        end else if (scan_step) begin
            mask_q <= rest;
        end
    end

endmodule

/* hw/core_sequencer.sv */
`timescale 1ns/1ps
// Program counter, instruction register and the per-instruction FSM
// Every memory answers one cycle after its strobe and nothing ever stalls
// After op_halt the FSM stays parked until rst
module core_sequencer #(
    parameter int num_pe = rosetta_pkg::num_pe
) (
    input  logic                        clk,
    input  logic                        rst,
    input  rosetta_pkg::inst_t          im_rdata,

    output logic                        im_ren,
    output rosetta_pkg::pc_t            im_raddr,
    output logic                        pam_x_ren,
    output logic                        am_x_ren,
    output rosetta_pkg::row_addr_t      x_raddr,
    output logic                        bm_ren,
    output rosetta_pkg::row_addr_t      bm_raddr,
    output logic                        wm_ren,
    output rosetta_pkg::waddr_t         wm_raddr,
    output logic                        am_r_wen,
    output rosetta_pkg::row_addr_t      am_r_waddr,
    output logic                        done,

    input  logic                        elem_valid,
    input  logic                        elem_last,
    input  logic [$clog2(num_pe)-1:0]   elem_idx,

    output logic                        mask_load,
    output logic                        scan_step,
    output logic                        row_load,
    output logic                        mac_step,
    output logic                        mac_clear
);

    rosetta_pkg::seq_state_e    state_q;
    rosetta_pkg::seq_state_e    state_d;
    rosetta_pkg::pc_t           pc_q;
    rosetta_pkg::inst_t         ir_q;
    rosetta_pkg::inst_t         inst;
    rosetta_pkg::opcode_e       opcode;
    logic                       started_q;
    logic                       is_decode;
    logic                       is_scan;
    logic                       is_load;

    assign is_decode = (state_q == rosetta_pkg::st_decode);
    assign is_load   = (state_q == rosetta_pkg::st_load);
    assign is_scan   = (state_q == rosetta_pkg::st_scan);

    // The fetched word is only on im_rdata during decode, the IR holds it afterwards
    assign inst   = is_decode ? im_rdata : ir_q;
    assign opcode = rosetta_pkg::opcode_e'(inst[rosetta_pkg::op_msb:rosetta_pkg::op_lsb]);

    always_comb begin
        state_d = state_q;
        case (state_q)
            rosetta_pkg::st_fetch: begin
                if (im_ren) begin
                    state_d = rosetta_pkg::st_decode;
                end
            end
            rosetta_pkg::st_decode: begin
                case (opcode)
                    rosetta_pkg::op_mvma: state_d = rosetta_pkg::st_load;
                    rosetta_pkg::op_halt: state_d = rosetta_pkg::st_halt;
                    default:              state_d = rosetta_pkg::st_fetch;
                endcase
            end
            rosetta_pkg::st_load:  state_d = rosetta_pkg::st_scan;
            rosetta_pkg::st_scan: begin
                // An empty mask falls straight through without a weight read
                if (!elem_valid || elem_last) begin
                    state_d = rosetta_pkg::st_drain;
                end
            end
            rosetta_pkg::st_drain: state_d = rosetta_pkg::st_write;
            rosetta_pkg::st_write: state_d = rosetta_pkg::st_fetch;
            default:               state_d = rosetta_pkg::st_halt;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= rosetta_pkg::st_fetch;
            pc_q      <= '0;
            started_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            started_q <= 1'b1;
            if (im_ren) begin
                pc_q <= pc_q + rosetta_pkg::pc_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (is_decode) begin
            ir_q <= im_rdata;
        end
    end

    // Fetch waits one cycle after reset so no strobe shows while rst is high
    assign im_ren   = started_q && (state_q == rosetta_pkg::st_fetch);
    assign im_raddr = pc_q;

    assign pam_x_ren = is_decode && (opcode == rosetta_pkg::op_mvma);
    assign am_x_ren  = pam_x_ren;
    assign bm_ren    = pam_x_ren;
    assign x_raddr   = rosetta_pkg::row_addr_t'(inst[rosetta_pkg::x_msb:rosetta_pkg::x_lsb]);
    assign bm_raddr  = inst[rosetta_pkg::bias_msb:rosetta_pkg::bias_lsb];

    assign mask_load = is_load;
    assign row_load  = is_load;
    assign mac_clear = is_load;

    assign wm_ren    = is_scan && elem_valid;
    assign scan_step = wm_ren;
    assign mac_step  = wm_ren;
    assign wm_raddr  = inst[rosetta_pkg::wb_msb:rosetta_pkg::wb_lsb]
                     + rosetta_pkg::waddr_t'(elem_idx);

    assign am_r_wen   = (state_q == rosetta_pkg::st_write);
    assign am_r_waddr = inst[rosetta_pkg::dst_msb:rosetta_pkg::dst_lsb];

    assign done = (state_q == rosetta_pkg::st_halt);

endmodule

/* hw/rosetta_core.sv */
`timescale 1ns/1ps
// Top of the sparse matrix-vector engine
// All memories are external and answer one cycle after their read strobe
// num_pe must be a power of 2 and at least 2
module rosetta_core #(
    parameter int num_pe = rosetta_pkg::num_pe,
    parameter int word_w = rosetta_pkg::word_w
) (
    input  logic                          clk,
    input  logic                          rst,

    output logic                          im_ren,
    output rosetta_pkg::pc_t              im_raddr,
    input  rosetta_pkg::inst_t            im_rdata,

    output logic                          pam_x_ren,
    output rosetta_pkg::row_addr_t        pam_x_raddr,
    input  logic [num_pe-1:0]             pam_x_rdata,

    output logic                          am_x_ren,
    output rosetta_pkg::row_addr_t        am_x_raddr,
    input  logic [num_pe*word_w-1:0]      am_x_rdata,

    output logic                          bm_ren,
    output rosetta_pkg::row_addr_t        bm_raddr,
    input  logic [num_pe*word_w-1:0]      bm_rdata,

    output logic                          wm_ren,
    output rosetta_pkg::waddr_t           wm_raddr,
    input  logic [num_pe*word_w-1:0]      wm_rdata,

    output logic                          am_r_wen,
    output rosetta_pkg::row_addr_t        am_r_waddr,
    output logic [num_pe*word_w-1:0]      am_r_wdata,

    output logic                          done
);

    rosetta_pkg::row_addr_t     x_raddr;
    logic                       elem_valid;
    logic                       elem_last;
    logic [$clog2(num_pe)-1:0]  elem_idx;
    logic                       mask_load;
    logic                       scan_step;
    logic                       row_load;
    logic                       mac_step;
    logic                       mac_clear;

    // Presence and activation rows share one row address
    assign pam_x_raddr = x_raddr;
    assign am_x_raddr  = x_raddr;

    core_sequencer #(
        .num_pe(num_pe)
    ) sequencer_inst (
        .clk        (clk),
        .rst        (rst),
        .im_rdata   (im_rdata),
        .im_ren     (im_ren),
        .im_raddr   (im_raddr),
        .pam_x_ren  (pam_x_ren),
        .am_x_ren   (am_x_ren),
        .x_raddr    (x_raddr),
        .bm_ren     (bm_ren),
        .bm_raddr   (bm_raddr),
        .wm_ren     (wm_ren),
        .wm_raddr   (wm_raddr),
        .am_r_wen   (am_r_wen),
        .am_r_waddr (am_r_waddr),
        .done       (done),
        .elem_valid (elem_valid),
        .elem_last  (elem_last),
        .elem_idx   (elem_idx),
        .mask_load  (mask_load),
        .scan_step  (scan_step),
        .row_load   (row_load),
        .mac_step   (mac_step),
        .mac_clear  (mac_clear)
    );

    zero_skip_unit #(
        .num_pe(num_pe)
    ) zero_skip_inst (
        .clk        (clk),
        .rst        (rst),
        .mask_load  (mask_load),
        .scan_step  (scan_step),
        .mask_in    (pam_x_rdata),
        .elem_valid (elem_valid),
        .elem_idx   (elem_idx),
        .elem_last  (elem_last)
    );

    mac_array #(
        .num_pe(num_pe),
        .word_w(word_w)
    ) mac_array_inst (
        .clk        (clk),
        .rst        (rst),
        .row_load   (row_load),
        .mac_clear  (mac_clear),
        .mac_step   (mac_step),
        .elem_idx   (elem_idx),
        .act_row    (am_x_rdata),
        .bias_row   (bm_rdata),
        .weight_row (wm_rdata),
        .result_row (am_r_wdata)
    );

endmodule

/* dv/tb_mem_model.sv */
`timescale 1ns/1ps
// Behavioral memories around the core, each answering one cycle after its read strobe
// Contents are loaded by the testbench through hierarchical writes before reset ends
// The result memory keeps the last row written to each address
module tb_mem_model #(
    parameter int num_pe = rosetta_pkg::num_pe,
    parameter int word_w = rosetta_pkg::word_w
) (
    input  logic                        clk,

    input  logic                        im_ren,
    input  rosetta_pkg::pc_t            im_raddr,
    output rosetta_pkg::inst_t          im_rdata,

    input  logic                        pam_x_ren,
    input  rosetta_pkg::row_addr_t      pam_x_raddr,
    output logic [num_pe-1:0]           pam_x_rdata,

    input  logic                        am_x_ren,
    input  rosetta_pkg::row_addr_t      am_x_raddr,
    output logic [num_pe*word_w-1:0]    am_x_rdata,

    input  logic                        bm_ren,
    input  rosetta_pkg::row_addr_t      bm_raddr,
    output logic [num_pe*word_w-1:0]    bm_rdata,

    input  logic                        wm_ren,
    input  rosetta_pkg::waddr_t         wm_raddr,
    output logic [num_pe*word_w-1:0]    wm_rdata,

    input  logic                        am_r_wen,
    input  rosetta_pkg::row_addr_t      am_r_waddr,
    input  logic [num_pe*word_w-1:0]    am_r_wdata
);

    rosetta_pkg::inst_t         imem [256];
    logic [num_pe-1:0]          pam  [32];
    logic [num_pe*word_w-1:0]   amx  [32];
    logic [num_pe*word_w-1:0]   bm   [32];
    logic [num_pe*word_w-1:0]   wm   [2048];
    logic [num_pe*word_w-1:0]   res  [32];

    initial begin
        im_rdata    = '0;
        pam_x_rdata = '0;
        am_x_rdata  = '0;
        bm_rdata    = '0;
        wm_rdata    = '0;
    end

    always @(posedge clk) begin
        if (im_ren) begin
            im_rdata <= imem[im_raddr];
        end
        if (pam_x_ren) begin
            pam_x_rdata <= pam[pam_x_raddr];
        end
        if (am_x_ren) begin
            am_x_rdata <= amx[am_x_raddr];
        end
        if (bm_ren) begin
            bm_rdata <= bm[bm_raddr];
        end
        if (wm_ren) begin
            wm_rdata <= wm[wm_raddr];
        end
        if (am_r_wen) begin
            res[am_r_waddr] <= am_r_wdata;
        end
    end

endmodule

/* dv/tb_top.sv */
`timescale 1ns/1ps
// Self-checking testbench for rosetta_core running an LCG-built program
// Concurrent assertions check every strobe and stop the run at the first error
// The program assumes num_pe <= 12 and word_w <= 16
module tb_top;

    localparam int num_pe    = rosetta_pkg::num_pe;
    localparam int word_w    = rosetta_pkg::word_w;
    localparam int rw        = num_pe * word_w;
    localparam int prog_len  = 16;
    localparam int num_mv    = 12;
    localparam int cyc_limit = prog_len * (num_pe + 8) + 50;
    localparam logic [word_w-1:0] sat_max = {1'b0, {(word_w-1){1'b1}}};
    localparam logic [word_w-1:0] sat_min = {1'b1, {(word_w-1){1'b0}}};

    logic                       clk = 1'b0;
    logic                       rst;
    logic                       im_ren;
    rosetta_pkg::pc_t           im_raddr;
    rosetta_pkg::inst_t         im_rdata;
    logic                       pam_x_ren;
    rosetta_pkg::row_addr_t     pam_x_raddr;
    logic [num_pe-1:0]          pam_x_rdata;
    logic                       am_x_ren;
    rosetta_pkg::row_addr_t     am_x_raddr;
    logic [rw-1:0]              am_x_rdata;
    logic                       bm_ren;
    rosetta_pkg::row_addr_t     bm_raddr;
    logic [rw-1:0]              bm_rdata;
    logic                       wm_ren;
    rosetta_pkg::waddr_t        wm_raddr;
    logic [rw-1:0]              wm_rdata;
    logic                       am_r_wen;
    rosetta_pkg::row_addr_t     am_r_waddr;
    logic [rw-1:0]              am_r_wdata;
    logic                       done;

    logic [31:0]                lcg_state;
    int                         cur_pc;
    int                         fetch_addr;
    int                         wm_cnt;
    int                         inst_writes;
    int                         total_writes;
    int                         cycle_cnt;
    logic                       have_inst;
    logic                       fetch_q;
    logic                       done_seen;
    logic                       rst_q;
    logic                       lanes_saturated;

    // Expected behavior per program address
    logic [rw-1:0]              exp_row    [prog_len];
    rosetta_pkg::row_addr_t     exp_dst    [prog_len];
    rosetta_pkg::row_addr_t     exp_xa     [prog_len];
    rosetta_pkg::row_addr_t     exp_ba     [prog_len];
    int                         exp_nw     [prog_len];
    rosetta_pkg::waddr_t        exp_wa     [prog_len][num_pe];
    logic                       is_mv      [prog_len];
    logic                       is_halt    [prog_len];
    logic                       is_extreme [prog_len];

    always #50 clk = ~clk;

    rosetta_core #(
        .num_pe(num_pe),
        .word_w(word_w)
    ) rosetta_core_inst (
        .clk         (clk),
        .rst         (rst),
        .im_ren      (im_ren),
        .im_raddr    (im_raddr),
        .im_rdata    (im_rdata),
        .pam_x_ren   (pam_x_ren),
        .pam_x_raddr (pam_x_raddr),
        .pam_x_rdata (pam_x_rdata),
        .am_x_ren    (am_x_ren),
        .am_x_raddr  (am_x_raddr),
        .am_x_rdata  (am_x_rdata),
        .bm_ren      (bm_ren),
        .bm_raddr    (bm_raddr),
        .bm_rdata    (bm_rdata),
        .wm_ren      (wm_ren),
        .wm_raddr    (wm_raddr),
        .wm_rdata    (wm_rdata),
        .am_r_wen    (am_r_wen),
        .am_r_waddr  (am_r_waddr),
        .am_r_wdata  (am_r_wdata),
        .done        (done)
    );

    tb_mem_model #(
        .num_pe(num_pe),
        .word_w(word_w)
    ) mem_inst (
        .clk         (clk),
        .im_ren      (im_ren),
        .im_raddr    (im_raddr),
        .im_rdata    (im_rdata),
        .pam_x_ren   (pam_x_ren),
        .pam_x_raddr (pam_x_raddr),
        .pam_x_rdata (pam_x_rdata),
        .am_x_ren    (am_x_ren),
        .am_x_raddr  (am_x_raddr),
        .am_x_rdata  (am_x_rdata),
        .bm_ren      (bm_ren),
        .bm_raddr    (bm_raddr),
        .bm_rdata    (bm_rdata),
        .wm_ren      (wm_ren),
        .wm_raddr    (wm_raddr),
        .wm_rdata    (wm_rdata),
        .am_r_wen    (am_r_wen),
        .am_r_waddr  (am_r_waddr),
        .am_r_wdata  (am_r_wdata)
    );

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [rw-1:0] rand_row(input logic nonzero);
        logic [rw-1:0]  row;
        logic [31:0]    r;
        for (int e = 0; e < num_pe; e++) begin
            r = next_rand();
            row[e*word_w +: word_w] = r[16 +: word_w];
            if (nonzero && row[e*word_w +: word_w] == '0) begin
                row[e*word_w +: word_w] = word_w'(1);
            end
        end
        return row;
    endfunction

    function automatic int signed_elem(input logic [rw-1:0] row, input int k);
        logic signed [word_w-1:0] w;
        w = row[k*word_w +: word_w];
        return int'(w);
    endfunction

    // Bias plus the sparse dot product of the row, clamped to the signed word range
    function automatic logic [rw-1:0] golden_row(input logic [num_pe-1:0] mask,
            input logic [rw-1:0] act, input logic [rw-1:0] bias,
            input rosetta_pkg::waddr_t wb);
        logic [rw-1:0]          out;
        rosetta_pkg::waddr_t    wa;
        int                     acc;
        int                     max_v;
        max_v = (1 << (word_w - 1)) - 1;
        for (int p = 0; p < num_pe; p++) begin
            acc = signed_elem(bias, p);
            for (int k = 0; k < num_pe; k++) begin
                wa = wb + rosetta_pkg::waddr_t'(k);
                if (mask[num_pe-1-k]) begin
                    acc += signed_elem(act, k) * signed_elem(mem_inst.wm[wa], p);
                end
            end
            if (acc > max_v) begin
                acc = max_v;
            end else if (acc < -max_v - 1) begin
                acc = -max_v - 1;
            end
            out[p*word_w +: word_w] = word_w'(acc);
        end
        return out;
    endfunction

    task automatic build_program();
        rosetta_pkg::inst_t     inst;
        rosetta_pkg::row_addr_t dst;
        rosetta_pkg::row_addr_t bsel;
        rosetta_pkg::waddr_t    wb;
        logic [num_pe-1:0]      mask;
        logic [rw-1:0]          row;
        logic [31:0]            r;
        int                     mv;
        int                     n;
        lcg_state = 32'd85439;
        for (int a = 0; a < 2048; a++) begin
            mem_inst.wm[a] = rand_row(1'b0);
        end
        // Inactive activation elements stay nonzero so a wrong skip shows up
        for (int a = 0; a < 32; a++) begin
            r = next_rand();
            mem_inst.pam[a] = r[20 +: num_pe];
            mem_inst.amx[a] = rand_row(1'b1);
            mem_inst.bm[a]  = rand_row(1'b0);
        end
        // Unused program slots halt and carry their own address in the ignored fields
        for (int a = 0; a < 256; a++) begin
            mem_inst.imem[a] = {2'(rosetta_pkg::op_halt), 8'(a), 22'd0};
        end
        mv = 0;
        for (int pc = 0; pc < prog_len; pc++) begin
            is_mv[pc]      = 1'b0;
            is_halt[pc]    = (pc == prog_len - 1);
            is_extreme[pc] = 1'b0;
            exp_nw[pc]     = 0;
            exp_dst[pc]    = '0;
            exp_xa[pc]     = '0;
            exp_ba[pc]     = '0;
            exp_row[pc]    = '0;
            r = next_rand();
            if (pc % 4 == 3 && pc != prog_len - 1) begin
                mem_inst.imem[pc] = {2'(rosetta_pkg::op_nop), r[29:0]};
            end else if (pc != prog_len - 1) begin
                dst  = r[4:0];
                bsel = r[9:5];
                wb   = rosetta_pkg::waddr_t'(int'(r[31:16]) % (2048 - num_pe));
                mask = mem_inst.pam[mv];
                if (mv == 2) begin
                    mask = '0;
                end else if (mv == 5 || mv == 8) begin
                    mask = '1;
                end
                mem_inst.pam[mv] = mask;
                // Full negative activations against alternating extreme weights
                if (mv == 8) begin
                    is_extreme[pc] = 1'b1;
                    for (int e = 0; e < num_pe; e++) begin
                        row[e*word_w +: word_w] = (e % 2 == 0) ? sat_min : sat_max;
                    end
                    mem_inst.amx[mv] = {num_pe{sat_min}};
                    for (int k = 0; k < num_pe; k++) begin
                        mem_inst.wm[wb + rosetta_pkg::waddr_t'(k)] = row;
                    end
                end
                mem_inst.imem[pc] = {2'(rosetta_pkg::op_mvma), dst, bsel, 4'(mv), wb, 5'd0};
                is_mv[pc]   = 1'b1;
                exp_dst[pc] = dst;
                exp_xa[pc]  = rosetta_pkg::row_addr_t'(mv);
                exp_ba[pc]  = bsel;
                n = 0;
                for (int k = 0; k < num_pe; k++) begin
                    if (mask[num_pe-1-k]) begin
                        exp_wa[pc][n] = wb + rosetta_pkg::waddr_t'(k);
                        n++;
                    end
                end
                exp_nw[pc] = n;
                mv++;
            end
        end
        // Golden rows only once every memory row is final
        for (int pc = 0; pc < prog_len; pc++) begin
            inst = mem_inst.imem[pc];
            if (is_mv[pc]) begin
                exp_row[pc] = golden_row(mem_inst.pam[inst[19:16]], mem_inst.amx[inst[19:16]],
                                         mem_inst.bm[inst[24:20]], inst[15:5]);
            end
        end
    endtask

    function automatic logic captured_rows_ok();
        logic [rw-1:0]  last_row [32];
        logic           written  [32];
        logic           ok;
        ok = 1'b1;
        for (int a = 0; a < 32; a++) begin
            written[a] = 1'b0;
        end
        for (int pc = 0; pc < prog_len; pc++) begin
            if (is_mv[pc]) begin
                last_row[exp_dst[pc]] = exp_row[pc];
                written[exp_dst[pc]]  = 1'b1;
            end
        end
        for (int a = 0; a < 32; a++) begin
            if (written[a] && mem_inst.res[a] !== last_row[a]) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    always_comb begin
        lanes_saturated = 1'b1;
        for (int p = 0; p < num_pe; p++) begin
            if (am_r_wdata[p*word_w +: word_w] != sat_max &&
                am_r_wdata[p*word_w +: word_w] != sat_min) begin
                lanes_saturated = 1'b0;
            end
        end
    end

    // Tracks which program address is executing and counts its strobes
    always @(posedge clk) begin
        rst_q <= rst;
        if (rst) begin
            cur_pc       <= 0;
            fetch_addr   <= 0;
            wm_cnt       <= 0;
            inst_writes  <= 0;
            total_writes <= 0;
            cycle_cnt    <= 0;
            have_inst    <= 1'b0;
            fetch_q      <= 1'b0;
            done_seen    <= 1'b0;
        end else begin
            cycle_cnt <= cycle_cnt + 1;
            fetch_q   <= im_ren;
            if (im_ren) begin
                cur_pc      <= int'(im_raddr);
                fetch_addr  <= int'(im_raddr) + 1;
                have_inst   <= 1'b1;
                wm_cnt      <= 0;
                inst_writes <= 0;
            end else begin
                if (wm_ren) begin
                    wm_cnt <= wm_cnt + 1;
                end
                if (am_r_wen) begin
                    inst_writes <= inst_writes + 1;
                end
            end
            if (am_r_wen) begin
                total_writes <= total_writes + 1;
            end
            if (done) begin
                done_seen <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst && cycle_cnt >= cyc_limit) begin
            stop_run($sformatf("Timeout: done not raised within %0d cycles", cyc_limit));
        end
    end

    a_reset_quiet: assert property (@(posedge clk) (rst || rst_q) |->
            !(im_ren || pam_x_ren || am_x_ren || bm_ren || wm_ren || am_r_wen || done))
        else stop_run($sformatf("[FAIL] %0t ns: strobe or done high around reset", $time));

    a_fetch_addr: assert property (@(posedge clk) disable iff (rst)
            im_ren |-> int'(im_raddr) == fetch_addr)
        else stop_run($sformatf("[FAIL] %0t ns: fetch address %0d, expected %0d",
                                $time, im_raddr, fetch_addr));

    // Row reads belong to the decode cycle of an op_mvma and use its own fields
    a_row_reads: assert property (@(posedge clk) disable iff (rst)
            (pam_x_ren || am_x_ren || bm_ren || (fetch_q && is_mv[cur_pc])) |->
            (fetch_q && is_mv[cur_pc] && pam_x_ren && am_x_ren && bm_ren &&
             pam_x_raddr == exp_xa[cur_pc] && am_x_raddr == exp_xa[cur_pc] &&
             bm_raddr == exp_ba[cur_pc]))
        else stop_run($sformatf("[FAIL] %0t ns: pc %0d row reads at x %0d/%0d and bias %0d",
                                $time, cur_pc, pam_x_raddr, am_x_raddr, bm_raddr));

    a_inst_complete: assert property (@(posedge clk) disable iff (rst)
            (im_ren && have_inst) |->
            (inst_writes == int'(is_mv[cur_pc]) && wm_cnt == exp_nw[cur_pc]))
        else stop_run($sformatf("[FAIL] %0t ns: pc %0d made %0d writes and %0d weight reads",
                                $time, cur_pc, inst_writes, wm_cnt));

    a_weight_order: assert property (@(posedge clk) disable iff (rst)
            wm_ren |-> (wm_cnt < exp_nw[cur_pc] && wm_raddr == exp_wa[cur_pc][wm_cnt]))
        else stop_run($sformatf("[FAIL] %0t ns: unexpected weight read at %0d for pc %0d",
                                $time, wm_raddr, cur_pc));

    a_write_addr: assert property (@(posedge clk) disable iff (rst)
            am_r_wen |-> (is_mv[cur_pc] && inst_writes == 0 && am_r_waddr == exp_dst[cur_pc]))
        else stop_run($sformatf("[FAIL] %0t ns: unexpected result write at %0d for pc %0d",
                                $time, am_r_waddr, cur_pc));

    a_write_data: assert property (@(posedge clk) disable iff (rst)
            am_r_wen |-> am_r_wdata == exp_row[cur_pc])
        else stop_run($sformatf("[FAIL] %0t ns: pc %0d wrote %h, expected %h",
                                $time, cur_pc, am_r_wdata, exp_row[cur_pc]));

    a_saturated: assert property (@(posedge clk) disable iff (rst)
            (am_r_wen && is_extreme[cur_pc]) |-> lanes_saturated)
        else stop_run($sformatf("[FAIL] %0t ns: extreme row %h not fully saturated",
                                $time, am_r_wdata));

    a_done_source: assert property (@(posedge clk) disable iff (rst)
            done |-> (have_inst && is_halt[cur_pc]))
        else stop_run($sformatf("[FAIL] %0t ns: done raised at pc %0d", $time, cur_pc));

    a_done_hold: assert property (@(posedge clk) disable iff (rst)
            done_seen |-> (done && !im_ren && !wm_ren && !am_r_wen))
        else stop_run($sformatf("[FAIL] %0t ns: activity or done drop after halt", $time));

    initial begin
        rst = 1'b1;
        build_program();
        repeat (8) @(negedge clk);
        rst = 1'b0;
        wait (done);
        repeat (4) @(negedge clk);
        if (total_writes == num_mv && captured_rows_ok()) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            stop_run($sformatf("[FAIL] %0t ns: result memory does not hold the expected rows",
                               $time));
        end
    end

endmodule

/* tb.f */
hw/rosetta_pkg.sv
hw/mac_lane.sv
hw/mac_array.sv
hw/zero_skip_unit.sv
hw/core_sequencer.sv
hw/rosetta_core.sv
dv/tb_mem_model.sv
dv/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator, run the simulation and decide the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f tb.f -o tb_sim \
    || { echo "RESULT: build failed"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log

grep -q "Test failed" sim.log \
    && { echo "RESULT: FAIL"; exit 1; } \
    || { echo "RESULT: PASS"; exit 0; }
